//--- Makefile
# Verilator build and run of the pipelined CPU testbench
SIM = obj_dir/cpu_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module cpu_tb -f files.f -o cpu_sim

run: compile
	./$(SIM) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/cpu_pkg.sv
// ******************************
// Shared types for the pipelined CPU
// Opcodes, ALU codes, instruction and control structs
// Forwarding record and Wishbone request and response
// ******************************
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [4:0] {
        OP_RTYPE = 5'b00000,
        OP_J     = 5'b00001,
        OP_BNE   = 5'b00010,
        OP_ADDI  = 5'b00101,
        OP_BLT   = 5'b00110,
        OP_SW    = 5'b00111,
        OP_LW    = 5'b01000
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_e;

    // Immediate overlays rt, shamt and alu_op; jump target overlays bits 26..0
    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rd;
        reg_addr_t rs;
        reg_addr_t rt;
        logic [4:0] shamt;
        alu_op_e   alu_op;
        logic [1:0] pad;
    } instr_t;

    // All zero is a bubble
    typedef struct packed {
        logic      reg_we;
        logic      mem_we;
        logic      mem_rd;
        logic      use_imm;
        alu_op_e   alu_op;
        reg_addr_t dest;
        logic      uses_rs;
        logic      uses_rt_or_rd;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        word_t     value;
    } fwd_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        word_t dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    function automatic word_t imm_sext(instr_t i);
        word_t raw;
        raw = i;
        return {{15{raw[16]}}, raw[16:0]};
    endfunction

    function automatic word_t jump_target(instr_t i);
        word_t raw;
        raw = i;
        return {5'b00000, raw[26:0]};
    endfunction

    // Stores and branches take their second source from rd
    function automatic reg_addr_t src_b(instr_t i);
        if (i.opcode inside {OP_SW, OP_BNE, OP_BLT})
            return i.rd;
        return i.rt;
    endfunction

    // Register 0 never matches a forwarding source
    function automatic logic fwd_hit(fwd_t f, reg_addr_t a);
        return f.valid && (f.dest == a) && (a != '0);
    endfunction

endpackage

`default_nettype wire

//--- design/decode_stage.sv
// ******************************
// Decode stage
// Control decode, branch compare, hazard stall
// Decode/execute register
// ******************************
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic            clock,
    input  logic            rst,
    input  cpu_pkg::instr_t fd_instr,
    input  cpu_pkg::word_t  fd_pc_plus1,
    input  logic            mem_stall,
    input  cpu_pkg::fwd_t   fwd_xm,
    input  cpu_pkg::fwd_t   fwd_mw,
    input  logic            xm_is_load,
    output logic            hazard_stall,
    output logic            redirect,
    output cpu_pkg::word_t  redirect_pc,
    output cpu_pkg::ctrl_t  dx_ctrl,
    output cpu_pkg::instr_t dx_instr,
    output cpu_pkg::word_t  dx_a,
    output cpu_pkg::word_t  dx_b
);
    import cpu_pkg::*;

    logic      is_r, is_addi, is_lw, is_sw, is_bne, is_blt, is_j, is_branch;
    reg_addr_t addr_b;
    word_t     rf_a, rf_b, cmp_a, cmp_b;
    ctrl_t     dec;
    logic      dx_hit_a, dx_hit_b, xm_ld_a, xm_ld_b;
    logic      load_use, branch_wait, taken;

    assign is_r      = fd_instr.opcode == OP_RTYPE;
    assign is_addi   = fd_instr.opcode == OP_ADDI;
    assign is_lw     = fd_instr.opcode == OP_LW;
    assign is_sw     = fd_instr.opcode == OP_SW;
    assign is_bne    = fd_instr.opcode == OP_BNE;
    assign is_blt    = fd_instr.opcode == OP_BLT;
    assign is_j      = fd_instr.opcode == OP_J;
    assign is_branch = is_bne | is_blt;
    assign addr_b    = src_b(fd_instr);

    // Writeback port doubles as the writeback bypass
    reg_file u_reg_file (
        .clock     (clock),
        .rst       (rst),
        .rd_a_addr (fd_instr.rs),
        .rd_b_addr (addr_b),
        .wr_addr   (fwd_mw.dest),
        .rd_a_data (rf_a),
        .rd_b_data (rf_b),
        .wr_en     (fwd_mw.valid),
        .wr_data   (fwd_mw.value)
    );

    always_comb begin
        dec = '0;
        if (word_t'(fd_instr) != '0) begin
            dec.reg_we        = (is_r | is_addi | is_lw) && (fd_instr.rd != '0);
            dec.mem_we        = is_sw;
            dec.mem_rd        = is_lw;
            dec.use_imm       = is_addi | is_lw | is_sw;
            dec.alu_op        = is_r ? fd_instr.alu_op : ALU_ADD;
            dec.dest          = dec.reg_we ? fd_instr.rd : '0;
            dec.uses_rs       = is_r | is_addi | is_lw | is_sw | is_branch;
            dec.uses_rt_or_rd = is_r | is_sw | is_branch;
        end
    end

    // Comparator operands, execute/memory result first
    assign cmp_a = fwd_hit(fwd_xm, fd_instr.rs) ? fwd_xm.value : rf_a;
    assign cmp_b = fwd_hit(fwd_xm, addr_b) ? fwd_xm.value : rf_b;

    // A live dest is never register 0
    assign dx_hit_a = dx_ctrl.reg_we && (dx_ctrl.dest == fd_instr.rs);
    assign dx_hit_b = dx_ctrl.reg_we && (dx_ctrl.dest == addr_b);
    assign xm_ld_a  = xm_is_load && (fwd_xm.dest == fd_instr.rs);
    assign xm_ld_b  = xm_is_load && (fwd_xm.dest == addr_b);

    assign load_use = dx_ctrl.mem_rd &&
                      ((dec.uses_rs && dx_hit_a) || (dec.uses_rt_or_rd && dx_hit_b));
    assign branch_wait  = is_branch && (dx_hit_a || dx_hit_b || xm_ld_a || xm_ld_b);
    assign hazard_stall = load_use | branch_wait;

    // blt is taken when rd < rs, signed
    assign taken = (is_bne && (cmp_a != cmp_b)) ||
                   (is_blt && ($signed(cmp_b) < $signed(cmp_a)));
    assign redirect    = (taken | is_j) & ~hazard_stall;
    assign redirect_pc = is_j ? jump_target(fd_instr) : fd_pc_plus1 + imm_sext(fd_instr);

    always_ff @(posedge clock) begin
        if (rst) begin
            dx_ctrl <= '0;
        end else if (!mem_stall) begin
            dx_ctrl <= hazard_stall ? ctrl_t'('0) : dec;
        end
    end

    // While frozen, operands still pick up the retiring writeback
    always_ff @(posedge clock) begin
        if (mem_stall) begin
            if (fwd_hit(fwd_mw, dx_instr.rs))
                dx_a <= fwd_mw.value;
            if (fwd_hit(fwd_mw, src_b(dx_instr)))
                dx_b <= fwd_mw.value;
        end else begin
            dx_instr <= fd_instr;
            dx_a     <= rf_a;
            dx_b     <= rf_b;
        end
    end

endmodule

`default_nettype wire

//--- design/execute_stage.sv
// ******************************
// Execute stage
// Operand forwarding, ALU, execute/memory register
// ******************************
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic            clock,
    input  logic            rst,
    input  logic            mem_stall,
    input  cpu_pkg::ctrl_t  dx_ctrl,
    input  cpu_pkg::instr_t dx_instr,
    input  cpu_pkg::word_t  dx_a,
    input  cpu_pkg::word_t  dx_b,
    input  cpu_pkg::fwd_t   fwd_mw,
    output cpu_pkg::fwd_t   fwd_xm,
    output logic            xm_is_load,
    output cpu_pkg::ctrl_t  xm_ctrl,
    output cpu_pkg::word_t  xm_result,
    output cpu_pkg::word_t  xm_store_data
);
    import cpu_pkg::*;

    reg_addr_t addr_b;
    word_t     op_a, op_b, alu_b, alu_y;

    assign addr_b = src_b(dx_instr);

    // Youngest producer wins
    always_comb begin
        op_a = dx_a;
        if (fwd_hit(fwd_xm, dx_instr.rs))
            op_a = fwd_xm.value;
        else if (fwd_hit(fwd_mw, dx_instr.rs))
            op_a = fwd_mw.value;

        op_b = dx_b;
        if (fwd_hit(fwd_xm, addr_b))
            op_b = fwd_xm.value;
        else if (fwd_hit(fwd_mw, addr_b))
            op_b = fwd_mw.value;
    end

    assign alu_b = dx_ctrl.use_imm ? imm_sext(dx_instr) : op_b;

    // Arithmetic wraps
    always_comb begin
        case (dx_ctrl.alu_op)
            ALU_SUB: alu_y = op_a - alu_b;
            ALU_AND: alu_y = op_a & alu_b;
            ALU_OR:  alu_y = op_a | alu_b;
            ALU_SLL: alu_y = op_a << dx_instr.shamt;
            ALU_SRA: alu_y = word_t'($signed(op_a) >>> dx_instr.shamt);
            default: alu_y = op_a + alu_b;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            xm_ctrl <= '0;
        end else if (!mem_stall) begin
            xm_ctrl <= dx_ctrl;
        end
    end

    always_ff @(posedge clock) begin
        if (!mem_stall) begin
            xm_result     <= alu_y;
            xm_store_data <= op_b;
        end
    end

    // Load data is not ready yet in this stage
    assign xm_is_load   = xm_ctrl.mem_rd & xm_ctrl.reg_we;
    assign fwd_xm.valid = xm_ctrl.reg_we & ~xm_ctrl.mem_rd;
    assign fwd_xm.dest  = xm_ctrl.dest;
    assign fwd_xm.value = xm_result;

endmodule

`default_nettype wire

//--- design/fetch_stage.sv
// ******************************
// Fetch stage
// PC, next-PC select and fetch/decode register
// ******************************
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter cpu_pkg::word_t RESET_VECTOR = 32'h0
) (
    input  logic            clock,
    input  logic            rst,
    input  logic            stall,
    input  logic            redirect,
    input  cpu_pkg::word_t  redirect_pc,
    output cpu_pkg::word_t  imem_addr,
    input  cpu_pkg::word_t  imem_data,
    output cpu_pkg::instr_t fd_instr,
    output cpu_pkg::word_t  fd_pc_plus1
);
    import cpu_pkg::*;

    word_t pc;
    word_t pc_plus1;

    assign imem_addr = pc;
    assign pc_plus1  = pc + 32'd1;

    // A taken redirect squashes the word fetched this cycle
    always_ff @(posedge clock) begin
        if (rst) begin
            pc       <= RESET_VECTOR;
            fd_instr <= '0;
        end else if (!stall) begin
            pc       <= redirect ? redirect_pc : pc_plus1;
            fd_instr <= redirect ? instr_t'('0) : instr_t'(imem_data);
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_pc_plus1 <= pc_plus1;
        end
    end

endmodule

`default_nettype wire

//--- design/mem_wb_stage.sv
// ******************************
// Memory and writeback stage
// Wishbone classic master, memory/writeback register
// ******************************
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
    input  logic              clock,
    input  logic              rst,
    input  cpu_pkg::ctrl_t    xm_ctrl,
    input  cpu_pkg::word_t    xm_result,
    input  cpu_pkg::word_t    xm_store_data,
    output cpu_pkg::wb_req_t  wb_req,
    input  cpu_pkg::wb_rsp_t  wb_rsp,
    output logic              mem_stall,
    output cpu_pkg::fwd_t     fwd_mw
);
    import cpu_pkg::*;

    logic      mem_op, req, gap;
    logic      mw_reg_we, mw_is_load;
    reg_addr_t mw_dest;
    word_t     mw_alu, mw_load;

    assign mem_op = xm_ctrl.mem_rd | xm_ctrl.mem_we;

    // One idle cycle after every ack
    assign req       = mem_op & ~gap;
    assign mem_stall = mem_op & ~(req & wb_rsp.ack);

    always_ff @(posedge clock) begin
        if (rst) begin
            gap <= 1'b0;
        end else begin
            gap <= req & wb_rsp.ack;
        end
    end

    // Request fields come straight from the frozen execute/memory register
    assign wb_req.cyc = req;
    assign wb_req.stb = req;
    assign wb_req.we  = req & xm_ctrl.mem_we;
    assign wb_req.adr = xm_result;
    assign wb_req.dat = xm_store_data;

    // Bubble into writeback while the access waits
    always_ff @(posedge clock) begin
        if (rst) begin
            mw_reg_we <= 1'b0;
        end else begin
            mw_reg_we <= xm_ctrl.reg_we & ~mem_stall;
        end
    end

    always_ff @(posedge clock) begin
        mw_dest    <= xm_ctrl.dest;
        mw_is_load <= xm_ctrl.mem_rd;
        mw_alu     <= xm_result;
        mw_load    <= wb_rsp.dat;
    end

    // Writeback select
    assign fwd_mw.valid = mw_reg_we;
    assign fwd_mw.dest  = mw_dest;
    assign fwd_mw.value = mw_is_load ? mw_load : mw_alu;

endmodule

`default_nettype wire

//--- design/pipeline_top.sv
// ******************************
// Five-stage pipeline top level
// ******************************
`timescale 1ns/1ps
`default_nettype none

module pipeline_top #(
    parameter cpu_pkg::word_t RESET_VECTOR = 32'h0
) (
    input  logic             clock,
    input  logic             rst,
    output cpu_pkg::word_t   imem_addr,
    input  cpu_pkg::word_t   imem_data,
    output cpu_pkg::wb_req_t wb_req,
    input  cpu_pkg::wb_rsp_t wb_rsp
);
    import cpu_pkg::*;

    instr_t fd_instr, dx_instr;
    word_t  fd_pc_plus1, redirect_pc;
    word_t  dx_a, dx_b, xm_result, xm_store_data;
    ctrl_t  dx_ctrl, xm_ctrl;
    fwd_t   fwd_xm, fwd_mw;
    logic   mem_stall, hazard_stall, redirect, xm_is_load, fetch_stall;

    // PC and fetch/decode hold on either stall
    assign fetch_stall = mem_stall | hazard_stall;

    fetch_stage #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_fetch (
        .clock       (clock),
        .rst         (rst),
        .stall       (fetch_stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .fd_instr    (fd_instr),
        .fd_pc_plus1 (fd_pc_plus1)
    );

    decode_stage u_decode (
        .clock        (clock),
        .rst          (rst),
        .fd_instr     (fd_instr),
        .fd_pc_plus1  (fd_pc_plus1),
        .mem_stall    (mem_stall),
        .fwd_xm       (fwd_xm),
        .fwd_mw       (fwd_mw),
        .xm_is_load   (xm_is_load),
        .hazard_stall (hazard_stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .dx_ctrl      (dx_ctrl),
        .dx_instr     (dx_instr),
        .dx_a         (dx_a),
        .dx_b         (dx_b)
    );

    execute_stage u_execute (
        .clock         (clock),
        .rst           (rst),
        .mem_stall     (mem_stall),
        .dx_ctrl       (dx_ctrl),
        .dx_instr      (dx_instr),
        .dx_a          (dx_a),
        .dx_b          (dx_b),
        .fwd_mw        (fwd_mw),
        .fwd_xm        (fwd_xm),
        .xm_is_load    (xm_is_load),
        .xm_ctrl       (xm_ctrl),
        .xm_result     (xm_result),
        .xm_store_data (xm_store_data)
    );

    mem_wb_stage u_mem_wb (
        .clock         (clock),
        .rst           (rst),
        .xm_ctrl       (xm_ctrl),
        .xm_result     (xm_result),
        .xm_store_data (xm_store_data),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .mem_stall     (mem_stall),
        .fwd_mw        (fwd_mw)
    );

endmodule

`default_nettype wire

//--- design/reg_file.sv
// ******************************
// Register file, 32 x 32 bit
// Register 0 reads zero, writes pass through to reads
// ******************************
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic               clock,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t rd_a_addr,
    input  cpu_pkg::reg_addr_t rd_b_addr,
    input  cpu_pkg::reg_addr_t wr_addr,
    output cpu_pkg::word_t     rd_a_data,
    output cpu_pkg::word_t     rd_b_data,
    input  logic               wr_en,
    input  cpu_pkg::word_t     wr_data
);
    import cpu_pkg::*;

    word_t regs [0:31];
    logic  wr_live;

    assign wr_live = wr_en && (wr_addr != '0);

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-cycle write is visible on the read ports
    assign rd_a_data = (rd_a_addr == '0) ? '0 :
                       (wr_live && wr_addr == rd_a_addr) ? wr_data : regs[rd_a_addr];
    assign rd_b_data = (rd_b_addr == '0) ? '0 :
                       (wr_live && wr_addr == rd_b_addr) ? wr_data : regs[rd_b_addr];

endmodule

`default_nettype wire

//--- files.f
design/cpu_pkg.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/pipeline_top.sv
verification/cpu_checker.sv
verification/cpu_tb.sv

//--- verification/cpu_checker.sv
// ******************************
// Bound assertions on the Wishbone data port
// Bus release, request hold and reset behavior
// ******************************
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
    input logic             clock,
    input logic             rst,
    input cpu_pkg::wb_req_t wb_req,
    input cpu_pkg::wb_rsp_t wb_rsp
);

    // Bus dropped for at least one cycle after every ack
    idle_after_ack: assert property (@(posedge clock) disable iff (rst)
        (wb_req.stb && wb_rsp.ack) |=> (!wb_req.cyc && !wb_req.stb))
        else $error("bus not released after ack");

    // Request held unchanged until the slave acks
    req_held: assert property (@(posedge clock) disable iff (rst)
        (wb_req.stb && !wb_rsp.ack) |=>
        (wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.we) && $stable(wb_req.dat)))
        else $error("request changed or dropped before ack");

    no_write_in_reset: assert property (@(posedge clock)
        rst |-> !$rose(wb_req.we))
        else $error("we rose during reset");

endmodule

`default_nettype wire

//--- verification/cpu_tb.sv
// ******************************
// Testbench for the pipelined CPU
// Clock, reset, instruction and data memories
// Stimulus file reading, store checks and timeout
// ******************************
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam word_t RESET_VECTOR  = 32'h0;
    localparam int    RESET_CYCLES  = 16;
    localparam int    SETTLE_CYCLES = 24;

    logic    clock;
    logic    rst;
    word_t   imem_addr;
    word_t   imem_data;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp = '0;

    word_t imem [0:255];
    word_t dmem [0:255] = '{default: '0};

    // Parsed stimulus, flat queues indexed per test
    string test_name [$];
    int    prog_start [$];
    int    prog_len [$];
    int    store_start [$];
    int    store_cnt [$];
    word_t prog_words [$];
    word_t exp_adr [$];
    word_t exp_dat [$];

    int     cur_test;
    int     store_idx;
    int     stores_checked;
    int     mismatches;
    int     other_errors;
    logic   timed_out;
    integer seed = 32'he900;
    int     wait_left;
    logic   busy = 1'b0;

    pipeline_top #(
        .RESET_VECTOR (RESET_VECTOR)
    ) DUT (
        .clock     (clock),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

    bind pipeline_top cpu_checker u_checker (
        .clock  (clock),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    assign imem_data = imem[imem_addr[7:0]];

    // Data memory slave, 0 to 3 wait cycles per access
    always @(posedge clock) begin
        #1;
        wb_rsp.ack = 1'b0;
        if (wb_req.stb) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = $random(seed) & 3;
            end
            if (wait_left == 0) begin
                wb_rsp.ack = 1'b1;
                wb_rsp.dat = dmem[wb_req.adr[7:0]];
                if (wb_req.we) begin
                    dmem[wb_req.adr[7:0]] = wb_req.dat;
                end
                busy = 1'b0;
            end else begin
                wait_left--;
            end
        end else begin
            busy = 1'b0;
        end
    end

    task automatic compare_word(input string what, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            mismatches++;
            $display("mismatch %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic load_stim();
        int    fd;
        int    n;
        int    last;
        string tok;
        string rest;
        word_t value;
        word_t pend_adr;
        logic  in_stores;
        logic  have_adr;
        fd = $fopen("verification/prog_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/prog_stim.txt");
            other_errors++;
            return;
        end
        in_stores = 1'b0;
        have_adr  = 1'b0;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.getc(0) == 8'h23) begin
                n = $fgets(rest, fd);
            end else if (tok == "test") begin
                n = $fscanf(fd, "%s", tok);
                test_name.push_back(tok);
                prog_start.push_back(prog_words.size());
                prog_len.push_back(0);
                store_start.push_back(exp_adr.size());
                store_cnt.push_back(0);
                in_stores = 1'b0;
            end else if (tok == "stores") begin
                in_stores = 1'b1;
            end else if ($sscanf(tok, "%h", value) != 1 || test_name.size() == 0) begin
                $display("stimulus file has a token outside any test or not in hex: %s", tok);
                other_errors++;
            end else begin
                last = test_name.size() - 1;
                if (!in_stores) begin
                    prog_words.push_back(value);
                    prog_len[last] = prog_len[last] + 1;
                end else if (!have_adr) begin
                    pend_adr = value;
                    have_adr = 1'b1;
                end else begin
                    exp_adr.push_back(pend_adr);
                    exp_dat.push_back(value);
                    store_cnt[last] = store_cnt[last] + 1;
                    have_adr = 1'b0;
                end
            end
        end
        $fclose(fd);
    endtask

    // Compare one acked store with the next expected record of the test
    task automatic record_store();
        int last;
        last = store_start[cur_test] + store_cnt[cur_test];
        if (store_idx >= last) begin
            $display("test %s wrote %h to address %h with no expected store left",
                     test_name[cur_test], wb_req.dat, wb_req.adr);
            other_errors++;
        end else begin
            compare_word($sformatf("%s store %0d address", test_name[cur_test],
                         store_idx - store_start[cur_test]), exp_adr[store_idx], wb_req.adr);
            compare_word($sformatf("%s store %0d data", test_name[cur_test],
                         store_idx - store_start[cur_test]), exp_dat[store_idx], wb_req.dat);
            store_idx++;
            stores_checked++;
        end
    endtask

    // Sample the bus mid-cycle, then move to just after the next rising edge
    task automatic step_cycle();
        @(negedge clock);
        if (wb_req.stb && wb_rsp.ack && wb_req.we) begin
            record_store();
        end
        @(posedge clock);
        #1;
    endtask

    task automatic check_idle(input string phase);
        compare_word($sformatf("%s %s cyc", test_name[cur_test], phase), '0, word_t'(wb_req.cyc));
        compare_word($sformatf("%s %s stb", test_name[cur_test], phase), '0, word_t'(wb_req.stb));
        compare_word($sformatf("%s %s imem_addr", test_name[cur_test], phase),
                     RESET_VECTOR, imem_addr);
    endtask

    task automatic run_test(input int t);
        int    limit;
        int    cycles;
        int    last;
        word_t idx;
        cur_test = t;
        rst      = 1'b1;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < prog_len[t]; i++) begin
            idx = RESET_VECTOR + word_t'(i);
            imem[idx[7:0]] = prog_words[prog_start[t] + i];
        end
        $display("running test %s", test_name[t]);
        for (int i = 0; i < RESET_CYCLES; i++) begin
            step_cycle();
            check_idle("in reset");
        end
        rst = 1'b0;
        check_idle("after reset");
        last   = store_start[t] + store_cnt[t];
        limit  = 16 * prog_len[t] + 40 * store_cnt[t];
        cycles = 0;
        while (store_idx < last && cycles < limit) begin
            step_cycle();
            cycles++;
        end
        if (store_idx < last) begin
            $display("timeout in test %s after %0d cycles, %0d of %0d expected stores seen",
                     test_name[t], cycles, store_cnt[t] - (last - store_idx), store_cnt[t]);
            other_errors++;
            timed_out = 1'b1;
        end else begin
            // Quiet window to catch a stray wrong-path store
            repeat (SETTLE_CYCLES) step_cycle();
        end
    endtask

    initial begin
        rst            = 1'b1;
        store_idx      = 0;
        stores_checked = 0;
        mismatches     = 0;
        other_errors   = 0;
        timed_out      = 1'b0;
        cur_test       = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        load_stim();
        if (test_name.size() == 0) begin
            $display("no tests found in the stimulus file");
            other_errors++;
        end
        for (int t = 0; t < test_name.size(); t++) begin
            if (!timed_out) begin
                run_test(t);
            end
        end
        $display("checked %0d stores, %0d mismatches, %0d other errors",
                 stores_checked, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/prog_stim.txt
# test <name> opens a program: hex instruction words loaded from the reset vector on
# stores: expected data stores in order, as hex pairs of word address and data
test alu_chain
28400005 2883FFFE 00C22000 01061004   # addi r1 5, addi r2 r1 -2, add r3, sub r4
01480210 018A300C 01CC3008            # sll r5 r4 4, or r6 r5 r3, and r7 r6 r3
02046004 02500094                     # sub r8 r2 r6, sra r9 r8 1
3A400011 3A000010 39C00012 39400013   # sw r9, sw r8, sw r7, sw r5
0800000D                              # j to itself
stores
11 FFFFFFE5  10 FFFFFFCB  12 00000008  13 00000030
test load_use
28400123 38400020 40800020 00C41000   # addi r1 0x123, sw r1, lw r2, add r3 r2 r1
38C00021 41000021 39000022            # sw r3, lw r4, sw r4 right after the load
29880001 39800023 08000009            # addi r6 r4 1, sw r6, j to itself
stores
20 00000123  21 00000246  22 00000246  23 00000247
test branches
28400003 28800003 10820002 38400030   # r1 3, r2 3, bne not taken, sw r1
28840001 10820001 38800031            # r2 4, bne taken, squashed sw
30440001 38400032 30820001 38800033   # blt taken, squashed sw, blt not taken, sw r2
40C00033 10C40001 0800000F 38C00034   # lw r3, bne on load not taken, j, squashed sw
38C00035 08000010                     # sw r3, j to itself
stores
30 00000003  33 00000004  35 00000004
test loop_sum
28400004 28800000 00841000 38820040   # r1 4, r2 0, add r2 r2 r1, sw r2 at 64+r1
2843FFFF 3003FFFC 08000006            # addi r1 -1, blt r0 r1 back, j to itself
stores
44 00000004  43 00000007  42 00000009  41 0000000A
